// ==== src/epd_pkg.sv ====
// ====================
// EPD controller shared definitions
// ====================
`default_nettype none

package epd_pkg;

    // Pixel datapath
    localparam int PIX_PER_CLK = 4;
    localparam int VIN_W       = 32;
    localparam int STATE_W     = 16;
    localparam int BI_W        = 64;
    localparam int GRAY_W      = 4;
    localparam int DRV_W       = 2;

    // Waveform table, address is {seq, target, source}
    localparam int SEQ_W   = 6;
    localparam int LUT_AW  = 14;
    localparam int LUT_WAW = 12;

    // Scan timing
    localparam int CNT_W      = 11;
    localparam int VS_DELAY   = 8;
    localparam int PIPE_DELAY = 3;

    // Wishbone register map
    localparam int WB_AW = 4;
    localparam int WB_DW = 32;

    localparam logic [3:0] REG_CTRL      = 4'd0;
    localparam logic [3:0] REG_HTIM      = 4'd1;
    localparam logic [3:0] REG_HACT      = 4'd2;
    localparam logic [3:0] REG_VTIM      = 4'd3;
    localparam logic [3:0] REG_VACT      = 4'd4;
    localparam logic [3:0] REG_LUTFRAMES = 4'd5;
    localparam logic [3:0] REG_LUTADDR   = 4'd6;
    localparam logic [3:0] REG_LUTDATA   = 4'd7;
    localparam logic [3:0] REG_UPDATE    = 4'd8;
    localparam logic [3:0] REG_STATUS    = 4'd9;

    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_WAITING,
        SCAN_RUNNING
    } scan_state_t;

endpackage

`default_nettype wire

// ==== src/epd_csr.sv ====
// ====================
// Wishbone register block
// ====================
`timescale 1ns/1ps
`default_nettype none

module epd_csr (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [epd_pkg::WB_AW-1:0]   wb_adr,
    input  logic [epd_pkg::WB_DW-1:0]   wb_dat_w,
    output logic [epd_pkg::WB_DW-1:0]   wb_dat_r,
    output logic                        wb_ack,
    input  logic                        frame_start,
    input  logic                        upd_done,
    output logic                        global_en,
    output logic [7:0]                  hfp,
    output logic [7:0]                  hsync,
    output logic [7:0]                  hbp,
    output logic [7:0]                  vfp,
    output logic [7:0]                  vsync,
    output logic [7:0]                  vbp,
    output logic [11:0]                 hact,
    output logic [11:0]                 vact,
    output logic [epd_pkg::SEQ_W-1:0]   lut_frames,
    output logic                        lut_we,
    output logic [epd_pkg::LUT_WAW-1:0] lut_waddr,
    output logic [7:0]                  lut_wdata,
    output logic                        upd_active
);
    import epd_pkg::*;

    logic wr_en;
    logic upd_pending;

    // Writes land in the ack cycle while the master still holds the bus
    assign wr_en     = wb_ack && wb_cyc && wb_stb && wb_we;
    assign lut_we    = wr_en && (wb_adr == REG_LUTDATA);
    assign lut_wdata = wb_dat_w[7:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack      <= 1'b0;
            global_en   <= 1'b0;
            upd_pending <= 1'b0;
            upd_active  <= 1'b0;
        end else begin
            wb_ack <= wb_cyc && wb_stb && !wb_ack;
            if (wr_en && wb_adr == REG_CTRL) begin
                global_en <= wb_dat_w[0];
            end
            // A running update finishes before the next one is taken
            if (frame_start && (!upd_active || upd_done)) begin
                upd_active  <= upd_pending;
                upd_pending <= 1'b0;
            end
            if (wr_en && wb_adr == REG_UPDATE) begin
                upd_pending <= 1'b1;
            end
        end
    end

    // Configuration payload
    always_ff @(posedge clk) begin
        if (wr_en) begin
            case (wb_adr)
                REG_HTIM: {hbp, hsync, hfp} <= wb_dat_w[23:0];
                REG_HACT: hact <= wb_dat_w[11:0];
                REG_VTIM: {vbp, vsync, vfp} <= wb_dat_w[23:0];
                REG_VACT: vact <= wb_dat_w[11:0];
                REG_LUTFRAMES: lut_frames <= wb_dat_w[SEQ_W-1:0];
                REG_LUTADDR: lut_waddr <= wb_dat_w[LUT_WAW-1:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        wb_dat_r = '0;
        case (wb_adr)
            REG_CTRL:      wb_dat_r[0] = global_en;
            REG_HTIM:      wb_dat_r[23:0] = {hbp, hsync, hfp};
            REG_HACT:      wb_dat_r[11:0] = hact;
            REG_VTIM:      wb_dat_r[23:0] = {vbp, vsync, vfp};
            REG_VACT:      wb_dat_r[11:0] = vact;
            REG_LUTFRAMES: wb_dat_r[SEQ_W-1:0] = lut_frames;
            REG_LUTADDR:   wb_dat_r[LUT_WAW-1:0] = lut_waddr;
            REG_STATUS:    wb_dat_r[1:0] = {upd_pending, upd_active};
            default:       wb_dat_r = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/scan_timing.sv ====
// ====================
// Scan timing and frame sequencing
// ====================
`timescale 1ns/1ps
`default_nettype none

module scan_timing (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      global_en,
    input  logic                      vin_vsync,
    input  logic [7:0]                hfp,
    input  logic [7:0]                hsync,
    input  logic [7:0]                hbp,
    input  logic [11:0]               hact,
    input  logic [7:0]                vfp,
    input  logic [7:0]                vsync,
    input  logic [7:0]                vbp,
    input  logic [11:0]               vact,
    input  logic [epd_pkg::SEQ_W-1:0] lut_frames,
    input  logic                      upd_active,
    input  logic                      vin_valid,
    output logic                      frame_start,
    output logic                      upd_done,
    output logic                      b_trigger,
    output logic                      s1_active,
    output logic                      frame_valid,
    output logic [epd_pkg::SEQ_W-1:0] seq,
    output logic                      last_frame,
    output logic                      epd_gdoe,
    output logic                      epd_gdclk,
    output logic                      epd_gdsp,
    output logic                      epd_sdle,
    output logic                      epd_sdoe,
    output logic                      epd_sdce0,
    output logic                      epd_sdclk_en
);
    import epd_pkg::*;

    scan_state_t      state;
    logic [CNT_W-1:0] h_cnt;
    logic [CNT_W-1:0] v_cnt;
    logic [SEQ_W-1:0] fcnt;
    logic             fs_q;
    logic             running;

    // Region boundaries
    wire [CNT_W-1:0] h_bp_start  = CNT_W'(hfp) + CNT_W'(hsync);
    wire [CNT_W-1:0] h_act_start = h_bp_start + CNT_W'(hbp);
    wire [CNT_W-1:0] htotal      = h_act_start + CNT_W'(hact);
    wire [CNT_W-1:0] v_bp_start  = CNT_W'(vfp) + CNT_W'(vsync);
    wire [CNT_W-1:0] v_act_start = v_bp_start + CNT_W'(vbp);
    wire [CNT_W-1:0] vtotal      = v_act_start + CNT_W'(vact);

    assign running = (state == SCAN_RUNNING);

    wire in_hfp   = running && (h_cnt < CNT_W'(hfp));
    wire in_hsync = running && (h_cnt >= CNT_W'(hfp)) && (h_cnt < h_bp_start);
    wire in_hbp   = running && (h_cnt >= h_bp_start) && (h_cnt < h_act_start);
    wire in_hact  = running && (h_cnt >= h_act_start);
    wire in_vsync = running && (v_cnt >= CNT_W'(vfp)) && (v_cnt < v_bp_start);
    wire in_vbp   = running && (v_cnt >= v_bp_start) && (v_cnt < v_act_start);
    wire in_vact  = running && (v_cnt >= v_act_start);

    assign frame_start = (state == SCAN_WAITING) && (h_cnt == CNT_W'(VS_DELAY));
    assign b_trigger   = (state == SCAN_WAITING);

    // Input accept window opens ahead of the active region by the pipe depth
    assign s1_active = in_vact && (h_cnt >= h_act_start - CNT_W'(PIPE_DELAY))
                       && (h_cnt < htotal - CNT_W'(PIPE_DELAY));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SCAN_IDLE;
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            case (state)
                SCAN_IDLE: begin
                    h_cnt <= '0;
                    v_cnt <= '0;
                    if (global_en && vin_vsync) begin
                        state <= SCAN_WAITING;
                    end
                end
                SCAN_WAITING: begin
                    h_cnt <= frame_start ? '0 : h_cnt + 1'b1;
                    if (frame_start) begin
                        state <= SCAN_RUNNING;
                    end
                end
                SCAN_RUNNING: begin
                    if (h_cnt == htotal - 1'b1) begin
                        h_cnt <= '0;
                        if (v_cnt == vtotal - 1'b1) begin
                            state <= SCAN_IDLE;
                        end else begin
                            v_cnt <= v_cnt + 1'b1;
                        end
                    end else begin
                        h_cnt <= h_cnt + 1'b1;
                    end
                end
                default: state <= SCAN_IDLE;
            endcase
        end
    end

    // Frame counter steps one cycle after frame_start, once upd_active has settled
    always_ff @(posedge clk) begin
        if (rst) begin
            fs_q        <= 1'b0;
            fcnt        <= '0;
            frame_valid <= 1'b0;
            epd_gdclk   <= 1'b0;
        end else begin
            fs_q      <= frame_start;
            epd_gdclk <= in_hsync || in_hbp || in_hact;
            if (fs_q) begin
                if (upd_active && fcnt == '0) begin
                    fcnt <= lut_frames - 1'b1;
                end else if (fcnt != '0) begin
                    fcnt <= fcnt - 1'b1;
                end
            end
            // Underrun kills the rest of the frame
            if (frame_start) begin
                frame_valid <= 1'b1;
            end else if (s1_active && !vin_valid) begin
                frame_valid <= 1'b0;
            end
        end
    end

    assign seq        = lut_frames - 1'b1 - fcnt;
    assign upd_done   = (fcnt == '0);
    assign last_frame = (fcnt == '0);

    // Driver strobes
    assign epd_gdoe     = in_vsync || in_vbp || in_vact;
    assign epd_sdoe     = epd_gdoe;
    assign epd_gdsp     = !in_vsync;
    assign epd_sdle     = in_hsync;
    assign epd_sdce0    = !(in_vact && in_hact);
    assign epd_sdclk_en = in_hfp || in_hsync || in_hact;

endmodule

`default_nettype wire

// ==== src/wvfm_lut.sv ====
// ====================
// Waveform lookup table
// ====================
`timescale 1ns/1ps
`default_nettype none

module wvfm_lut (
    input  logic                        clk,
    input  logic                        we,
    input  logic [epd_pkg::LUT_WAW-1:0] waddr,
    input  logic [7:0]                  wdata,
    input  logic [epd_pkg::LUT_AW-1:0]  raddr0,
    input  logic [epd_pkg::LUT_AW-1:0]  raddr1,
    input  logic [epd_pkg::LUT_AW-1:0]  raddr2,
    input  logic [epd_pkg::LUT_AW-1:0]  raddr3,
    output logic [7:0]                  rdata
);
    import epd_pkg::*;

    // Each byte packs four 2-bit entries, lowest entry in bits 1:0
    logic [7:0]        mem [2**LUT_WAW];
    logic [LUT_AW-1:0] raddr [PIX_PER_CLK];

    assign raddr[0] = raddr0;
    assign raddr[1] = raddr1;
    assign raddr[2] = raddr2;
    assign raddr[3] = raddr3;

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < PIX_PER_CLK; i++) begin
            rdata[i*DRV_W +: DRV_W] <=
                mem[raddr[i][LUT_AW-1:2]][raddr[i][1:0]*DRV_W +: DRV_W];
        end
    end

endmodule

`default_nettype wire

// ==== src/pixel_pipe.sv ====
// ====================
// Pixel waveform pipeline
// ====================
`timescale 1ns/1ps
`default_nettype none

module pixel_pipe (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       s1_active,
    input  logic                       frame_valid,
    input  logic                       upd_active,
    input  logic                       last_frame,
    input  logic [epd_pkg::SEQ_W-1:0]  seq,
    input  logic [epd_pkg::VIN_W-1:0]  vin_pixel,
    input  logic [epd_pkg::BI_W-1:0]   bi_pixel,
    output logic [epd_pkg::LUT_AW-1:0] lut_raddr0,
    output logic [epd_pkg::LUT_AW-1:0] lut_raddr1,
    output logic [epd_pkg::LUT_AW-1:0] lut_raddr2,
    output logic [epd_pkg::LUT_AW-1:0] lut_raddr3,
    input  logic [7:0]                 lut_rdata,
    output logic [7:0]                 epd_sd,
    output logic [epd_pkg::BI_W-1:0]   bo_pixel,
    output logic                       bo_valid
);
    import epd_pkg::*;

    localparam int PIX_W = VIN_W / PIX_PER_CLK;

    logic                          s1_act;
    logic                          s2_act;
    logic [PIX_PER_CLK*GRAY_W-1:0] s1_tgt;
    logic [PIX_PER_CLK*GRAY_W-1:0] s2_tgt;
    logic [BI_W-1:0]               s1_bi;
    logic [BI_W-1:0]               s2_bi;
    logic [BI_W-1:0]               bo_next;
    logic                          drive_en;
    logic                          wb_en;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_act   <= 1'b0;
            s2_act   <= 1'b0;
            bo_valid <= 1'b0;
            epd_sd   <= '0;
        end else begin
            s1_act   <= s1_active;
            s2_act   <= s1_act;
            bo_valid <= s2_act;
            epd_sd   <= drive_en ? lut_rdata : '0;
        end
    end

    // Stage 1 keeps the Y4 target, stage 2 waits on the table read
    always_ff @(posedge clk) begin
        for (int i = 0; i < PIX_PER_CLK; i++) begin
            s1_tgt[i*GRAY_W +: GRAY_W] <= vin_pixel[i*PIX_W + PIX_W - GRAY_W +: GRAY_W];
        end
        s1_bi    <= bi_pixel;
        s2_tgt   <= s1_tgt;
        s2_bi    <= s1_bi;
        bo_pixel <= bo_next;
    end

    assign lut_raddr0 = {seq, s1_tgt[0*GRAY_W +: GRAY_W], s1_bi[0*STATE_W +: GRAY_W]};
    assign lut_raddr1 = {seq, s1_tgt[1*GRAY_W +: GRAY_W], s1_bi[1*STATE_W +: GRAY_W]};
    assign lut_raddr2 = {seq, s1_tgt[2*GRAY_W +: GRAY_W], s1_bi[2*STATE_W +: GRAY_W]};
    assign lut_raddr3 = {seq, s1_tgt[3*GRAY_W +: GRAY_W], s1_bi[3*STATE_W +: GRAY_W]};

    // Stage 3
    assign drive_en = s2_act && frame_valid && upd_active;
    assign wb_en    = frame_valid && upd_active && last_frame;

    always_comb begin
        bo_next = s2_bi;
        if (wb_en) begin
            for (int i = 0; i < PIX_PER_CLK; i++) begin
                bo_next[i*STATE_W +: GRAY_W] = s2_tgt[i*GRAY_W +: GRAY_W];
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/epd_ctrl_top.sv ====
// ====================
// EPD controller top
// ====================
`timescale 1ns/1ps
`default_nettype none

module epd_ctrl_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [epd_pkg::WB_AW-1:0] wb_adr,
    input  logic [epd_pkg::WB_DW-1:0] wb_dat_w,
    output logic [epd_pkg::WB_DW-1:0] wb_dat_r,
    output logic                      wb_ack,
    input  logic                      vin_vsync,
    input  logic [epd_pkg::VIN_W-1:0] vin_pixel,
    input  logic                      vin_valid,
    output logic                      vin_ready,
    output logic                      b_trigger,
    input  logic [epd_pkg::BI_W-1:0]  bi_pixel,
    input  logic                      bi_valid,
    output logic                      bi_ready,
    output logic [epd_pkg::BI_W-1:0]  bo_pixel,
    output logic                      bo_valid,
    output logic                      epd_gdoe,
    output logic                      epd_gdclk,
    output logic                      epd_gdsp,
    output logic                      epd_sdle,
    output logic                      epd_sdoe,
    output logic                      epd_sdce0,
    output logic                      epd_sdclk_en,
    output logic [7:0]                epd_sd,
    output logic                      global_en
);
    import epd_pkg::*;

    logic [7:0]        hfp, hsync, hbp, vfp, vsync, vbp;
    logic [11:0]       hact, vact;
    logic [SEQ_W-1:0]  lut_frames, seq;
    logic              lut_we, upd_active, upd_done, frame_start;
    logic [LUT_WAW-1:0] lut_waddr;
    logic [7:0]        lut_wdata, lut_rdata;
    logic              s1_active, frame_valid, last_frame;
    logic              in_valid;
    logic              accept;
    logic [LUT_AW-1:0] raddr0, raddr1, raddr2, raddr3;

    assign vin_ready = s1_active;
    assign bi_ready  = s1_active;

    // Either input stream running dry counts as underrun
    assign in_valid  = vin_valid && bi_valid;
    // Only words taken with valid travel down the pipe
    assign accept    = s1_active && in_valid;

    epd_csr epd_csr_i (
        .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .frame_start, .upd_done, .global_en,
        .hfp, .hsync, .hbp, .vfp, .vsync, .vbp, .hact, .vact,
        .lut_frames, .lut_we, .lut_waddr, .lut_wdata, .upd_active
    );

    scan_timing scan_timing_i (
        .clk, .rst, .global_en, .vin_vsync,
        .hfp, .hsync, .hbp, .hact, .vfp, .vsync, .vbp, .vact,
        .lut_frames, .upd_active, .vin_valid(in_valid),
        .frame_start, .upd_done, .b_trigger, .s1_active, .frame_valid, .seq, .last_frame,
        .epd_gdoe, .epd_gdclk, .epd_gdsp, .epd_sdle, .epd_sdoe, .epd_sdce0, .epd_sdclk_en
    );

    wvfm_lut wvfm_lut_i (
        .clk, .we(lut_we), .waddr(lut_waddr), .wdata(lut_wdata),
        .raddr0, .raddr1, .raddr2, .raddr3, .rdata(lut_rdata)
    );

    pixel_pipe pixel_pipe_i (
        .clk, .rst, .s1_active(accept), .frame_valid, .upd_active, .last_frame, .seq,
        .vin_pixel, .bi_pixel,
        .lut_raddr0(raddr0), .lut_raddr1(raddr1), .lut_raddr2(raddr2), .lut_raddr3(raddr3),
        .lut_rdata, .epd_sd, .bo_pixel, .bo_valid
    );

endmodule

`default_nettype wire

// ==== verif/epd_sva.sv ====
// ====================
// EPD controller assertions
// ====================
`timescale 1ns/1ps
`default_nettype none

module epd_sva (
    input logic clk,
    input logic rst,
    input logic wb_ack,
    input logic vin_ready,
    input logic epd_gdoe,
    input logic b_trigger
);

    // Single-cycle acknowledge
    ack_one_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else $error("wb_ack stayed high for more than one cycle");

    // Pixels are only taken while the gate driver is enabled
    ready_in_gate: assert property (@(posedge clk) disable iff (rst) vin_ready |-> epd_gdoe)
        else $error("vin_ready high outside the gate output window");

    trigger_apart: assert property (@(posedge clk) disable iff (rst) !(b_trigger && vin_ready))
        else $error("b_trigger and vin_ready high together");

endmodule

`default_nettype wire

// ==== verif/tb_epd.sv ====
// ====================
// EPD controller testbench
// ====================
`timescale 1ns/1ps
`default_nettype none

module tb_epd;
    import epd_pkg::*;

    // Small screen
    localparam int HFP       = 2;
    localparam int HSYNC     = 2;
    localparam int HBP       = 2;
    localparam int HACT      = 4;
    localparam int VFP       = 1;
    localparam int VSYNC     = 1;
    localparam int VBP       = 1;
    localparam int VACT      = 3;
    localparam int HTOTAL    = HFP + HSYNC + HBP + HACT;
    localparam int VTOTAL    = VFP + VSYNC + VBP + VACT;
    localparam int FRAME_LEN = VS_DELAY + 1 + HTOTAL * VTOTAL;
    localparam int PIX_W     = VIN_W / PIX_PER_CLK;
    localparam int N_FRAMES  = 3;
    // Table bytes covering seq 0 to N_FRAMES-1
    localparam int LUT_BYTES = N_FRAMES * (2 ** (LUT_WAW - SEQ_W));
    localparam int WD_CYCLES = 20 * (FRAME_LEN + 40) + LUT_BYTES * 2 * 3 + 200;

    // Readback values for registers 1 to 6, already masked to field widths
    localparam logic [31:0] RB_VAL [6] = '{
        32'h00a5_3c81, 32'h0000_0b7e, 32'h0012_34f0,
        32'h0000_0e21, 32'h0000_002d, 32'h0000_0c4b
    };

    logic              clk;
    logic              rst;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [WB_AW-1:0]  wb_adr;
    logic [WB_DW-1:0]  wb_dat_w;
    logic [WB_DW-1:0]  wb_dat_r;
    logic              wb_ack;
    logic              vin_vsync;
    logic [VIN_W-1:0]  vin_pixel;
    logic              vin_valid;
    logic              vin_ready;
    logic              b_trigger;
    logic [BI_W-1:0]   bi_pixel;
    logic              bi_valid;
    logic              bi_ready;
    logic [BI_W-1:0]   bo_pixel;
    logic              bo_valid;
    logic              epd_gdoe;
    logic              epd_gdclk;
    logic              epd_gdsp;
    logic              epd_sdle;
    logic              epd_sdoe;
    logic              epd_sdce0;
    logic              epd_sdclk_en;
    logic [7:0]        epd_sd;
    logic              global_en;

    int                errors;
    int                checks;
    logic [31:0]       lfsr;
    logic [7:0]        lut_ref [2**LUT_WAW];
    // Expected outputs, one entry per accepted word
    int                due_q [$];
    logic [7:0]        sd_q [$];
    logic [BI_W-1:0]   bo_q [$];

    epd_ctrl_top epd_ctrl_top_i (
        .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .vin_vsync, .vin_pixel, .vin_valid, .vin_ready, .b_trigger,
        .bi_pixel, .bi_valid, .bi_ready, .bo_pixel, .bo_valid,
        .epd_gdoe, .epd_gdclk, .epd_gdsp, .epd_sdle, .epd_sdoe, .epd_sdce0,
        .epd_sdclk_en, .epd_sd, .global_en
    );

    bind epd_ctrl_top epd_sva epd_sva_i (
        .clk, .rst, .wb_ack, .vin_ready, .epd_gdoe, .b_trigger
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Galois LFSR, one step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[62:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return r;
    endfunction

    function automatic logic [7:0] lut_fill(input logic [LUT_WAW-1:0] a);
        return (a[7:0] * 8'd37) ^ {a[11:8], a[11:8]} ^ 8'h6c;
    endfunction

    // Entry {seq, target, source}, four entries per byte from bit 0 up
    function automatic logic [DRV_W-1:0] lut_code(input logic [SEQ_W-1:0] s,
                                                  input logic [GRAY_W-1:0] tgt,
                                                  input logic [GRAY_W-1:0] src);
        logic [LUT_AW-1:0] a;
        logic [7:0]        b;
        a = {s, tgt, src};
        b = lut_ref[a[LUT_AW-1:2]];
        return b[a[1:0] * DRV_W +: DRV_W];
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic wb_cycle(input logic we, input logic [WB_AW-1:0] adr,
                            input logic [WB_DW-1:0] wdata, output logic [WB_DW-1:0] rdata);
        int n;
        n = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        @(negedge clk);
        while (!wb_ack && n < 16) begin
            n++;
            @(negedge clk);
        end
        if (!wb_ack) begin
            errors++;
            $display("no Wishbone acknowledge for register %0d within 16 cycles", adr);
        end
        rdata = wb_dat_r;
        // Hold the bus through the ack edge so the write lands
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] data);
        logic [WB_DW-1:0] unused;
        wb_cycle(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] data);
        wb_cycle(1'b0, adr, '0, data);
    endtask

    // One frame from a vsync pulse, checking every output against the model
    task automatic run_frame(input logic upd, input logic [SEQ_W-1:0] seq_ref,
                             input logic last, input logic underrun);
        int               n;
        int               trig_n;
        int               rdy_n;
        int               run_n;
        logic             fv;
        logic [VIN_W-1:0] vp;
        logic [BI_W-1:0]  bp;
        logic [7:0]       sd;
        logic [BI_W-1:0]  bo;
        logic [GRAY_W-1:0] tgt;
        n      = 0;
        trig_n = 0;
        rdy_n  = 0;
        run_n  = 0;
        fv     = 1'b1;
        vin_vsync = 1'b1;
        @(negedge clk);
        vin_vsync = 1'b0;
        while (!b_trigger && n < 16) begin
            n++;
            @(negedge clk);
        end
        if (!b_trigger) begin
            errors++;
            $display("scan did not leave idle after the vsync pulse");
        end
        for (int c = 0; c < FRAME_LEN + PIPE_DELAY; c++) begin
            if (due_q.size() > 0 && due_q[0] == c) begin
                check_value("bo_valid", 64'(bo_valid), 64'(1'b1));
                check_value("epd_sd", 64'(epd_sd), 64'(sd_q.pop_front()));
                check_value("bo_pixel", bo_pixel, bo_q.pop_front());
                void'(due_q.pop_front());
            end else begin
                check_value("bo_valid between words", 64'(bo_valid), 64'(1'b0));
            end
            check_value("bi_ready", 64'(bi_ready), 64'(vin_ready));
            if (b_trigger) begin
                trig_n++;
            end
            vin_valid = 1'b1;
            if (vin_ready) begin
                rdy_n++;
                run_n++;
                vp = VIN_W'(rand_bits(VIN_W));
                bp = rand_bits(BI_W);
                vin_pixel = vp;
                bi_pixel  = bp;
                // Underrun on the first ready cycle of the second active line
                if (underrun && rdy_n == HACT + 1) begin
                    vin_valid = 1'b0;
                    fv = 1'b0;
                end else begin
                    sd = '0;
                    bo = bp;
                    for (int i = 0; i < PIX_PER_CLK; i++) begin
                        tgt = vp[i*PIX_W + PIX_W - GRAY_W +: GRAY_W];
                        if (upd && fv) begin
                            sd[i*DRV_W +: DRV_W] = lut_code(seq_ref, tgt, bp[i*STATE_W +: GRAY_W]);
                        end
                        if (upd && fv && last) begin
                            bo[i*STATE_W +: GRAY_W] = tgt;
                        end
                    end
                    due_q.push_back(c + PIPE_DELAY);
                    sd_q.push_back(sd);
                    bo_q.push_back(bo);
                end
            end else if (run_n != 0) begin
                check_value("ready run length", 64'(run_n), 64'(HACT));
                run_n = 0;
            end
            @(negedge clk);
        end
        check_value("b_trigger cycles", 64'(trig_n), 64'(VS_DELAY + 1));
        check_value("vin_ready cycles", 64'(rdy_n), 64'(HACT * VACT));
        check_value("words still in flight", 64'(due_q.size()), 64'(0));
    endtask

    task automatic reset_values();
        logic [WB_DW-1:0] rd;
        check_value("wb_ack", 64'(wb_ack), 64'(1'b0));
        check_value("vin_ready", 64'(vin_ready), 64'(1'b0));
        check_value("bi_ready", 64'(bi_ready), 64'(1'b0));
        check_value("bo_valid", 64'(bo_valid), 64'(1'b0));
        check_value("b_trigger", 64'(b_trigger), 64'(1'b0));
        check_value("epd_gdoe", 64'(epd_gdoe), 64'(1'b0));
        check_value("epd_gdclk", 64'(epd_gdclk), 64'(1'b0));
        check_value("epd_sdoe", 64'(epd_sdoe), 64'(1'b0));
        check_value("epd_sdle", 64'(epd_sdle), 64'(1'b0));
        check_value("epd_sdclk_en", 64'(epd_sdclk_en), 64'(1'b0));
        check_value("epd_gdsp", 64'(epd_gdsp), 64'(1'b1));
        check_value("epd_sdce0", 64'(epd_sdce0), 64'(1'b1));
        check_value("epd_sd", 64'(epd_sd), 64'(8'h00));
        check_value("global_en", 64'(global_en), 64'(1'b0));
        for (int i = 0; i < 6; i++) begin
            wb_write(WB_AW'(REG_HTIM + i), RB_VAL[i]);
            wb_read(WB_AW'(REG_HTIM + i), rd);
            check_value("register readback", 64'(rd), 64'(RB_VAL[i]));
        end
        wb_write(REG_CTRL, 32'h1);
        check_value("global_en after enable", 64'(global_en), 64'(1'b1));
        wb_read(REG_CTRL, rd);
        check_value("enable readback", 64'(rd[0]), 64'(1'b1));
        wb_write(REG_CTRL, 32'h0);
        check_value("global_en after disable", 64'(global_en), 64'(1'b0));
        wb_read(REG_STATUS, rd);
        check_value("status after reset", 64'(rd[1:0]), 64'(2'b00));
    endtask

    task automatic configure_screen();
        wb_write(REG_HTIM, {8'h00, 8'(HBP), 8'(HSYNC), 8'(HFP)});
        wb_write(REG_HACT, 32'(HACT));
        wb_write(REG_VTIM, {8'h00, 8'(VBP), 8'(VSYNC), 8'(VFP)});
        wb_write(REG_VACT, 32'(VACT));
        wb_write(REG_LUTFRAMES, 32'(N_FRAMES));
        wb_write(REG_CTRL, 32'h1);
    endtask

    task automatic program_lut();
        for (int a = 0; a < LUT_BYTES; a++) begin
            lut_ref[a] = lut_fill(LUT_WAW'(a));
            wb_write(REG_LUTADDR, 32'(a));
            wb_write(REG_LUTDATA, {24'h0, lut_ref[a]});
        end
    endtask

    task automatic update_frames();
        logic [WB_DW-1:0] rd;
        program_lut();
        wb_write(REG_UPDATE, 32'h1);
        wb_read(REG_STATUS, rd);
        check_value("status armed", 64'(rd[1:0]), 64'(2'b10));
        for (int f = 0; f < N_FRAMES; f++) begin
            run_frame(1'b1, SEQ_W'(f), f == N_FRAMES - 1, 1'b0);
            wb_read(REG_STATUS, rd);
            check_value("status during update", 64'(rd[1:0]), 64'(2'b01));
        end
    endtask

    task automatic idle_after_update();
        logic [WB_DW-1:0] rd;
        run_frame(1'b0, '0, 1'b0, 1'b0);
        wb_read(REG_STATUS, rd);
        check_value("status after update", 64'(rd[1:0]), 64'(2'b00));
    endtask

    task automatic underrun_recovery();
        wb_write(REG_UPDATE, 32'h1);
        run_frame(1'b1, SEQ_W'(0), 1'b0, 1'b1);
        run_frame(1'b1, SEQ_W'(1), 1'b0, 1'b0);
        run_frame(1'b1, SEQ_W'(2), 1'b1, 1'b0);
        idle_after_update();
    endtask

    initial begin
        errors    = 0;
        checks    = 0;
        lfsr      = 32'h71e9_6b99;
        rst       = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        vin_vsync = 1'b0;
        vin_pixel = '0;
        vin_valid = 1'b1;
        bi_pixel  = '0;
        bi_valid  = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        reset_values();
        configure_screen();
        run_frame(1'b0, '0, 1'b0, 1'b0);
        update_frames();
        idle_after_update();
        underrun_recovery();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Room for 20 frames plus table loading and register traffic
    initial begin
        #(WD_CYCLES * 10);
        $display("watchdog expired after %0d cycles, the run did not finish", WD_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
src/epd_pkg.sv
src/epd_csr.sv
src/scan_timing.sv
src/wvfm_lut.sv
src/pixel_pipe.sv
src/epd_ctrl_top.sv
verif/epd_sva.sv
verif/tb_epd.sv

// ==== Makefile ====
# Verilator build and run for the EPD controller testbench

VERILATOR ?= verilator
TOP       ?= tb_epd
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= test passed
VFLAGS    ?= --binary --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail is taken from the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
